/* hw/datapath_pkg.sv */
// datapath types and encodings
`default_nettype none

package datapath_pkg;

    // widths fixed by the ISA
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

    typedef enum logic [2:0] {
        fu_none,
        fu_alu,
        fu_load,
        fu_store,
        fu_branch,
        fu_jump,
        fu_halt
    } fu_sel_t;

    // rv32i major opcodes
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam instr_t     halt_word = 32'hffff_ffff;

    typedef struct packed {
        fu_sel_t  fu;
        alu_op_t  alu_op;
        reg_idx_t rd;
        word_t    rdat1;
        word_t    rdat2;
        word_t    imm;
        word_t    pc;
        logic     uses_imm;
        logic     is_bne;
    } issue_t;

    typedef struct packed {
        logic     valid;
        logic     wen;
        reg_idx_t rd;
        word_t    wdat;
        logic     halt;
    } result_t;

    typedef enum logic {
        mem_idle,
        mem_wait
    } mem_state_t;

endpackage

`default_nettype wire

/* hw/datapath_ifs.sv */
// pipeline stage interfaces
`timescale 1ns/1ps
`default_nettype none

interface fetch_if import datapath_pkg::*; ();
    instr_t instr;
    word_t  pc;
    logic   valid;
    logic   freeze;
    logic   redirect;
    word_t  correct_pc;

    modport fetch (output instr, pc, valid, input freeze, redirect, correct_pc);
    modport sb (input instr, pc, valid, output freeze);
    modport ex (output redirect, correct_pc);
endinterface

interface issue_if import datapath_pkg::*; ();
    issue_t out;
    logic   valid;
    logic   busy;
    logic   flush;

    modport sb (output out, valid, input busy, flush);
    modport ex (input out, valid, output busy, flush);
endinterface

interface result_if import datapath_pkg::*; ();
    result_t  res;
    logic     clear_en;
    reg_idx_t clear_rd;

    modport ex (output res);
    modport wb (input res, output clear_en, clear_rd);
    modport sb (input clear_en, clear_rd);
endinterface

interface regfile_if import datapath_pkg::*; ();
    reg_idx_t rsel1;
    reg_idx_t rsel2;
    word_t    rdat1;
    word_t    rdat2;
    logic     wen;
    reg_idx_t wsel;
    word_t    wdat;

    modport sb (output rsel1, rsel2, input rdat1, rdat2);
    modport wb (output wen, wsel, wdat);
    modport rf (input rsel1, rsel2, wen, wsel, wdat, output rdat1, rdat2);
endinterface

`default_nettype wire

/* hw/fetch_stage.sv */
// instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import datapath_pkg::*; #(
    parameter word_t reset_pc = 32'h0000_0000
) (
    input  logic   CLK,
    input  logic   nrst,
    input  logic   ihit,
    input  word_t  imemload,
    output logic   imemREN,
    output word_t  imemaddr,
    fetch_if.fetch fif
);
    word_t  pc;
    logic   started;
    logic   halted;
    logic   take;
    logic   valid_q;
    instr_t instr_q;
    word_t  pc_q;

    // no request in the first cycle out of reset
    assign imemaddr = pc;
    assign imemREN  = started && !halted && !fif.freeze;
    assign take     = imemREN && ihit;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc      <= reset_pc;
            started <= 1'b0;
            halted  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            started <= 1'b1;
            if (fif.redirect) begin
                pc      <= fif.correct_pc;
                halted  <= 1'b0;
                valid_q <= 1'b0;
            end else if (!fif.freeze) begin
                valid_q <= take;
                if (take) begin
                    pc <= pc + 32'd4;
                    // stop after the halt word until a redirect
                    if (imemload == halt_word)
                        halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (take && !fif.redirect) begin
            instr_q <= imemload;
            pc_q    <= pc;
        end
    end

    assign fif.instr = instr_q;
    assign fif.pc    = pc_q;
    assign fif.valid = valid_q;

    a_pc_aligned: assert property (@(posedge CLK) disable iff (!nrst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/scoreboard.sv */
// decode and scoreboard issue
`timescale 1ns/1ps
`default_nettype none

module scoreboard import datapath_pkg::*; (
    input logic   CLK,
    input logic   nrst,
    fetch_if.sb   fif,
    issue_if.sb   iif,
    result_if.sb  rif,
    regfile_if.sb rfif
);
    issue_t      dec;
    issue_t      out_q;
    logic        valid_q;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        writes_rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [31:0] busy_q;
    logic [31:0] busy_now;
    logic [31:0] clear_mask;
    logic [31:0] set_mask;
    logic        hazard;
    logic        fire;

    function automatic alu_op_t alu_decode(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        case (funct3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b010:  op = alu_slt;
            3'b100:  op = alu_xor;
            3'b110:  op = alu_or;
            3'b111:  op = alu_and;
            default: op = alu_add;
        endcase
        return op;
    endfunction

    assign rs1        = fif.instr[19:15];
    assign rs2        = fif.instr[24:20];
    assign rfif.rsel1 = rs1;
    assign rfif.rsel2 = rs2;

    always_comb begin
        dec       = '0;
        dec.pc    = fif.pc;
        dec.rd    = fif.instr[11:7];
        dec.rdat1 = rfif.rdat1;
        dec.rdat2 = rfif.rdat2;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        if (fif.instr == halt_word) begin
            dec.fu = fu_halt;
        end else begin
            case (fif.instr[6:0])
                op_rtype: begin
                    dec.fu     = fu_alu;
                    dec.alu_op = alu_decode(fif.instr[14:12], fif.instr[30]);
                    uses_rs1   = 1'b1;
                    uses_rs2   = 1'b1;
                    writes_rd  = 1'b1;
                end
                op_imm: begin
                    dec.fu       = fu_alu;
                    dec.alu_op   = alu_decode(fif.instr[14:12], 1'b0);
                    dec.imm      = {{20{fif.instr[31]}}, fif.instr[31:20]};
                    dec.uses_imm = 1'b1;
                    uses_rs1     = 1'b1;
                    writes_rd    = 1'b1;
                end
                op_load: begin
                    dec.fu    = fu_load;
                    dec.imm   = {{20{fif.instr[31]}}, fif.instr[31:20]};
                    uses_rs1  = 1'b1;
                    writes_rd = 1'b1;
                end
                op_store: begin
                    dec.fu   = fu_store;
                    dec.imm  = {{20{fif.instr[31]}}, fif.instr[31:25], fif.instr[11:7]};
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                end
                op_branch: begin
                    dec.fu     = fu_branch;
                    dec.imm    = {{19{fif.instr[31]}}, fif.instr[31], fif.instr[7],
                                  fif.instr[30:25], fif.instr[11:8], 1'b0};
                    dec.is_bne = fif.instr[12];
                    uses_rs1   = 1'b1;
                    uses_rs2   = 1'b1;
                end
                op_jal: begin
                    dec.fu    = fu_jump;
                    dec.imm   = {{11{fif.instr[31]}}, fif.instr[31], fif.instr[19:12],
                                 fif.instr[20], fif.instr[30:21], 1'b0};
                    writes_rd = 1'b1;
                end
                default: ;
            endcase
        end
        // no destination means rd reads as x0 downstream
        if (!writes_rd)
            dec.rd = '0;
    end

    // a register being written back this cycle is already free (write-first bypass)
    assign clear_mask = rif.clear_en ? (32'd1 << rif.clear_rd) : 32'd0;
    assign busy_now   = busy_q & ~clear_mask;
    assign hazard     = (uses_rs1 && busy_now[rs1]) || (uses_rs2 && busy_now[rs2]) ||
                        busy_now[dec.rd];
    assign fire       = fif.valid && !hazard && !iif.busy && !iif.flush;
    assign fif.freeze = fif.valid && (hazard || iif.busy);
    assign set_mask   = (fire && dec.rd != '0) ? (32'd1 << dec.rd) : 32'd0;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            busy_q <= busy_now | set_mask;
            if (iif.flush)
                valid_q <= 1'b0;
            else if (!iif.busy)
                valid_q <= fire;
        end
    end

    always_ff @(posedge CLK) begin
        if (fire)
            out_q <= dec;
    end

    assign iif.out   = out_q;
    assign iif.valid = valid_q;

    a_hold_while_busy: assert property (@(posedge CLK) disable iff (!nrst)
        iif.busy |=> valid_q && $stable(out_q));
    a_x0_never_busy: assert property (@(posedge CLK) disable iff (!nrst) !busy_q[0]);

endmodule

`default_nettype wire

/* hw/regfile.sv */
// integer register file
`timescale 1ns/1ps
`default_nettype none

module regfile import datapath_pkg::*; (
    input logic   CLK,
    input logic   nrst,
    regfile_if.rf rfif
);
    word_t regs [32];

    // x0 is never written so it reads zero
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (rfif.wen && rfif.wsel != '0) begin
            regs[rfif.wsel] <= rfif.wdat;
        end
    end

    // write-first bypass on both read ports
    always_comb begin
        rfif.rdat1 = regs[rfif.rsel1];
        rfif.rdat2 = regs[rfif.rsel2];
        if (rfif.wen && rfif.wsel != '0 && rfif.wsel == rfif.rsel1)
            rfif.rdat1 = rfif.wdat;
        if (rfif.wen && rfif.wsel != '0 && rfif.wsel == rfif.rsel2)
            rfif.rdat2 = rfif.wdat;
    end

endmodule

`default_nettype wire

/* hw/execute.sv */
// execute stage with alu, branch and load/store
`timescale 1ns/1ps
`default_nettype none

module execute import datapath_pkg::*; (
    input  logic  CLK,
    input  logic  nrst,
    issue_if.ex   iif,
    fetch_if.ex   fif,
    result_if.ex  rif,
    input  logic  dhit,
    input  word_t dmemload,
    output logic  dmemREN,
    output logic  dmemWEN,
    output word_t dmemaddr,
    output word_t dmemstore
);
    issue_t     ins;
    logic       vld;
    word_t      opb;
    word_t      alu_out;
    logic       taken;
    logic       redirect;
    logic       is_mem;
    logic       mem_done;
    mem_state_t state;
    word_t      mem_addr;
    word_t      mem_data;
    reg_idx_t   mem_rd;
    logic       mem_load;
    result_t    res_next;
    result_t    res_q;

    assign ins = iif.out;
    assign vld = iif.valid;
    assign opb = ins.uses_imm ? ins.imm : ins.rdat2;

    always_comb begin
        case (ins.alu_op)
            alu_sub: alu_out = ins.rdat1 - opb;
            alu_and: alu_out = ins.rdat1 & opb;
            alu_or:  alu_out = ins.rdat1 | opb;
            alu_xor: alu_out = ins.rdat1 ^ opb;
            alu_slt: alu_out = {31'd0, $signed(ins.rdat1) < $signed(opb)};
            default: alu_out = ins.rdat1 + opb;
        endcase
    end

    // beq taken on equal, bne on not equal
    assign taken          = (ins.rdat1 == ins.rdat2) ^ ins.is_bne;
    assign redirect       = vld && (ins.fu == fu_jump || (ins.fu == fu_branch && taken));
    assign fif.redirect   = redirect;
    assign fif.correct_pc = ins.pc + ins.imm;
    assign iif.flush      = redirect;

    assign is_mem   = vld && (ins.fu == fu_load || ins.fu == fu_store);
    assign mem_done = (state == mem_wait) && dhit;
    assign iif.busy = is_mem && !mem_done;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst)
            state <= mem_idle;
        else if (state == mem_idle && is_mem)
            state <= mem_wait;
        else if (mem_done)
            state <= mem_idle;
    end

    // request held steady while waiting for dhit
    always_ff @(posedge CLK) begin
        if (state == mem_idle && is_mem) begin
            mem_addr <= ins.rdat1 + ins.imm;
            mem_data <= ins.rdat2;
            mem_rd   <= ins.rd;
            mem_load <= ins.fu == fu_load;
        end
    end

    assign dmemREN   = (state == mem_wait) && mem_load;
    assign dmemWEN   = (state == mem_wait) && !mem_load;
    assign dmemaddr  = mem_addr;
    assign dmemstore = mem_data;

    always_comb begin
        res_next = '0;
        if (mem_done) begin
            res_next.valid = 1'b1;
            res_next.wen   = mem_load && mem_rd != '0;
            res_next.rd    = mem_rd;
            res_next.wdat  = dmemload;
        end else if (vld && !is_mem) begin
            res_next.valid = 1'b1;
            res_next.wen   = (ins.fu == fu_alu || ins.fu == fu_jump) && ins.rd != '0;
            res_next.rd    = ins.rd;
            // jal links pc + 4
            res_next.wdat  = (ins.fu == fu_jump) ? ins.pc + 32'd4 : alu_out;
            res_next.halt  = ins.fu == fu_halt;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst)
            res_q <= '0;
        else
            res_q <= res_next;
    end

    assign rif.res = res_q;

    a_one_strobe: assert property (@(posedge CLK) disable iff (!nrst) !(dmemREN && dmemWEN));

endmodule

`default_nettype wire

/* hw/writeback.sv */
// writeback stage
`timescale 1ns/1ps
`default_nettype none

module writeback import datapath_pkg::*; (
    input  logic  CLK,
    input  logic  nrst,
    result_if.wb  rif,
    regfile_if.wb rfif,
    output logic  halt
);
    logic wr_en;

    assign wr_en        = rif.res.valid && rif.res.wen;
    assign rfif.wen     = wr_en;
    assign rfif.wsel    = rif.res.rd;
    assign rfif.wdat    = rif.res.wdat;
    // busy bit released on the same edge as the write
    assign rif.clear_en = wr_en;
    assign rif.clear_rd = rif.res.rd;

    // sticky once a halt record retires
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst)
            halt <= 1'b0;
        else if (rif.res.valid && rif.res.halt)
            halt <= 1'b1;
    end

    a_no_x0_write: assert property (@(posedge CLK) disable iff (!nrst) wr_en |-> rif.res.rd != '0);

endmodule

`default_nettype wire

/* hw/sc_datapath.sv */
// scalar pipeline datapath top
`timescale 1ns/1ps
`default_nettype none

module sc_datapath import datapath_pkg::*; #(
    parameter word_t reset_pc = 32'h0000_0000
) (
    input  logic  CLK,
    input  logic  nrst,
    input  logic  ihit,
    input  word_t imemload,
    output logic  imemREN,
    output word_t imemaddr,
    input  logic  dhit,
    input  word_t dmemload,
    output logic  dmemREN,
    output logic  dmemWEN,
    output word_t dmemaddr,
    output word_t dmemstore,
    output logic  halt
);
    fetch_if   fif ();
    issue_if   iif ();
    result_if  rif ();
    regfile_if rfif ();

    fetch_stage #(
        .reset_pc (reset_pc)
    ) i_fetch (
        .CLK      (CLK),
        .nrst     (nrst),
        .ihit     (ihit),
        .imemload (imemload),
        .imemREN  (imemREN),
        .imemaddr (imemaddr),
        .fif      (fif.fetch)
    );

    scoreboard i_scoreboard (
        .CLK  (CLK),
        .nrst (nrst),
        .fif  (fif.sb),
        .iif  (iif.sb),
        .rif  (rif.sb),
        .rfif (rfif.sb)
    );

    regfile i_regfile (
        .CLK  (CLK),
        .nrst (nrst),
        .rfif (rfif.rf)
    );

    // execute also drives the fetch redirect
    execute i_execute (
        .CLK       (CLK),
        .nrst      (nrst),
        .iif       (iif.ex),
        .fif       (fif.ex),
        .rif       (rif.ex),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore)
    );

    writeback i_writeback (
        .CLK  (CLK),
        .nrst (nrst),
        .rif  (rif.wb),
        .rfif (rfif.wb),
        .halt (halt)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int reset_cycles = 5
) (
    output logic CLK,
    output logic nrst
);
    initial begin
        CLK  = 1'b0;
        nrst = 1'b0;
    end

    // 4 ns period
    always #2 CLK = ~CLK;

    // reset changes only on a falling edge
    task automatic pulse_reset();
        @(negedge CLK);
        nrst <= 1'b0;
        repeat (reset_cycles) @(posedge CLK);
        @(negedge CLK);
        nrst <= 1'b1;
    endtask

endmodule

`default_nettype wire

/* testbench/tb_datapath.sv */
// datapath testbench
`timescale 1ns/1ps
`default_nettype none

module tb_datapath import datapath_pkg::*; ();

    localparam word_t  start_pc     = 32'h0000_0000;
    localparam instr_t halt_instr   = 32'hffff_ffff;
    localparam int     halt_timeout = 2000;
    localparam int     seed         = 30064;
    // rv32i opcodes used by the encoders
    localparam logic [6:0] opc_imm  = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;

    logic  CLK;
    logic  nrst;
    logic  ihit     = 1'b0;
    word_t imemload = '0;
    logic  imemREN;
    word_t imemaddr;
    logic  dhit     = 1'b0;
    word_t dmemload = '0;
    logic  dmemREN;
    logic  dmemWEN;
    word_t dmemaddr;
    word_t dmemstore;
    logic  halt;

    word_t  imem [256];
    word_t  dmem [256];
    instr_t prog [$];
    word_t  exp_addrs [$];
    word_t  exp_data [$];
    word_t  store_addrs [$];

    logic  ipending = 1'b0;
    logic  dpending = 1'b0;
    int    iwait    = 0;
    int    dwait    = 0;
    word_t iaddr    = '0;

    tb_clock i_clock (
        .CLK  (CLK),
        .nrst (nrst)
    );

    sc_datapath #(
        .reset_pc (start_pc)
    ) i_dut (
        .CLK       (CLK),
        .nrst      (nrst),
        .ihit      (ihit),
        .imemload  (imemload),
        .imemREN   (imemREN),
        .imemaddr  (imemaddr),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .halt      (halt)
    );

    function automatic int word_index(input word_t addr);
        return int'(addr[9:2]);
    endfunction

    function automatic word_t fill_word(input word_t addr, input word_t salt);
        return addr ^ salt;
    endfunction

    function automatic instr_t rtype(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t itype(input logic [6:0] opc, input reg_idx_t rd,
                                     input reg_idx_t rs1, input word_t imm);
        // addi and lw both use funct3 0 or 2
        return {imm[11:0], rs1, (opc == opc_load) ? 3'b010 : 3'b000, rd, opc};
    endfunction

    function automatic instr_t stype(input reg_idx_t rs2, input reg_idx_t rs1,
                                     input word_t imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t btype(input logic [2:0] f3, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input word_t off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic instr_t jtype(input reg_idx_t rd, input word_t off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // memory models, both answer on the falling edge
    always @(negedge CLK) begin
        if (!nrst) begin
            ihit     <= 1'b0;
            dhit     <= 1'b0;
            ipending = 1'b0;
            dpending = 1'b0;
        end else begin
            // new fetch address restarts a 0 to 2 cycle delay
            if (!ipending || imemaddr != iaddr) begin
                ipending = 1'b1;
                iaddr    = imemaddr;
                iwait    = $urandom_range(2, 0);
            end else if (iwait > 0) begin
                iwait--;
            end
            ihit     <= (iwait == 0);
            imemload <= imem[word_index(imemaddr)];

            if (dmemREN || dmemWEN) begin
                // dhit 1 to 3 cycles after the strobe
                if (!dpending) begin
                    dpending = 1'b1;
                    dwait    = $urandom_range(2, 0);
                end else if (dwait > 0) begin
                    dwait--;
                end
                if (dwait == 0) begin
                    dhit <= 1'b1;
                    if (dmemWEN) begin
                        dmem[word_index(dmemaddr)] = dmemstore;
                        store_addrs.push_back(dmemaddr);
                    end else begin
                        dmemload <= dmem[word_index(dmemaddr)];
                    end
                end
            end else begin
                dhit     <= 1'b0;
                dpending = 1'b0;
            end
        end
    end

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic compare_pc(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: address 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic new_program();
        prog.delete();
        exp_addrs.delete();
        exp_data.delete();
    endtask

    task automatic emit(input instr_t w);
        prog.push_back(w);
    endtask

    task automatic expect_store(input word_t addr, input word_t value);
        exp_addrs.push_back(addr);
        exp_data.push_back(value);
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < 256; i++) begin
            // unused words decode as no operation
            imem[i] = (i < prog.size()) ? prog[i] : fill_word(4 * i, 32'h0bad_0000);
            dmem[i] = fill_word(4 * i, 32'hd00d_0000);
        end
        store_addrs.delete();
    endtask

    task automatic wait_for_halt(input string name);
        int cycles;
        cycles = 0;
        while (halt !== 1'b1 && cycles < halt_timeout) begin
            @(negedge CLK);
            cycles++;
        end
        if (halt !== 1'b1) begin
            $display("timeout: program %s did not halt within %0d cycles", name, halt_timeout);
            stop_on_failure();
        end
    endtask

    task automatic run_program(input string name);
        load_program();
        i_clock.pulse_reset();
        wait_for_halt(name);
    endtask

    // store order first, then the final memory words
    task automatic check_stores();
        int i;
        compare_word("store count", word_t'(store_addrs.size()), word_t'(exp_addrs.size()));
        for (i = 0; i < exp_addrs.size(); i++) begin
            compare_pc("dmemaddr", store_addrs[i], exp_addrs[i]);
            compare_word($sformatf("dmem[%h]", exp_addrs[i]), dmem[word_index(exp_addrs[i])],
                         exp_data[i]);
        end
    endtask

    task automatic expect_untouched(input word_t addr);
        compare_word($sformatf("dmem[%h]", addr), dmem[word_index(addr)],
                     fill_word(addr, 32'hd00d_0000));
    endtask

    task automatic alu_ops();
        word_t a;
        word_t b;
        word_t exp_vals [8];
        int    i;
        a = -300;
        b = 1001;
        new_program();
        emit(itype(opc_imm, 5'd1, 5'd0, a));
        emit(itype(opc_imm, 5'd2, 5'd0, b));
        emit(rtype(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(rtype(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
        emit(rtype(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        emit(rtype(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
        emit(rtype(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
        emit(rtype(7'h00, 3'b010, 5'd8, 5'd1, 5'd2));
        emit(rtype(7'h00, 3'b010, 5'd9, 5'd2, 5'd1));
        emit(itype(opc_imm, 5'd10, 5'd1, 32'd77));
        exp_vals[0] = a + b;
        exp_vals[1] = a - b;
        exp_vals[2] = a & b;
        exp_vals[3] = a | b;
        exp_vals[4] = a ^ b;
        exp_vals[5] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exp_vals[6] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
        exp_vals[7] = a + 32'd77;
        for (i = 0; i < 8; i++) begin
            emit(stype(reg_idx_t'(i + 3), 5'd0, 32'h200 + 4 * i));
            expect_store(32'h200 + 4 * i, exp_vals[i]);
        end
        emit(halt_instr);
        run_program("alu");
        check_stores();
    endtask

    task automatic dependence_chain();
        word_t v1;
        word_t v2;
        word_t v3;
        word_t v4;
        new_program();
        emit(itype(opc_imm, 5'd1, 5'd0, 32'd5));
        emit(rtype(7'h00, 3'b000, 5'd1, 5'd1, 5'd1));
        emit(itype(opc_imm, 5'd2, 5'd1, 32'd3));
        emit(rtype(7'h20, 3'b000, 5'd3, 5'd2, 5'd1));
        emit(rtype(7'h00, 3'b100, 5'd3, 5'd3, 5'd2));
        emit(rtype(7'h00, 3'b000, 5'd4, 5'd3, 5'd3));
        emit(stype(5'd4, 5'd0, 32'h220));
        emit(stype(5'd3, 5'd0, 32'h224));
        emit(halt_instr);
        v1 = 32'd5 + 32'd5;
        v2 = v1 + 32'd3;
        v3 = (v2 - v1) ^ v2;
        v4 = v3 + v3;
        expect_store(32'h220, v4);
        expect_store(32'h224, v3);
        run_program("chain");
        check_stores();
    endtask

    task automatic load_store_roundtrip();
        word_t p;
        int    pass;
        // repeated so that each run sees other dhit delays
        for (pass = 0; pass < 3; pass++) begin
            new_program();
            emit(itype(opc_load, 5'd1, 5'd0, 32'h240));
            emit(itype(opc_imm, 5'd1, 5'd1, 32'd1));
            emit(stype(5'd1, 5'd0, 32'h244));
            emit(itype(opc_imm, 5'd2, 5'd0, 32'h55));
            emit(stype(5'd2, 5'd0, 32'h248));
            emit(itype(opc_load, 5'd3, 5'd0, 32'h248));
            emit(itype(opc_imm, 5'd3, 5'd3, 32'd1));
            emit(stype(5'd3, 5'd0, 32'h24c));
            emit(itype(opc_load, 5'd4, 5'd0, 32'h24c));
            emit(rtype(7'h00, 3'b000, 5'd5, 5'd4, 5'd1));
            emit(stype(5'd5, 5'd0, 32'h250));
            emit(halt_instr);
            p = fill_word(32'h240, 32'hd00d_0000) + 32'd1;
            expect_store(32'h244, p);
            expect_store(32'h248, 32'h55);
            expect_store(32'h24c, 32'h56);
            expect_store(32'h250, 32'h56 + p);
            run_program("load store");
            check_stores();
        end
    endtask

    task automatic branch_and_jump();
        word_t jal_pc;
        new_program();
        emit(itype(opc_imm, 5'd1, 5'd0, 32'd7));
        emit(itype(opc_imm, 5'd2, 5'd0, 32'd7));
        emit(btype(3'b000, 5'd1, 5'd2, 32'd12));
        emit(stype(5'd1, 5'd0, 32'h280));
        emit(stype(5'd2, 5'd0, 32'h284));
        // not taken, falls through to the next store
        emit(btype(3'b001, 5'd1, 5'd2, 32'd8));
        emit(stype(5'd1, 5'd0, 32'h288));
        jal_pc = start_pc + 4 * prog.size();
        emit(jtype(5'd5, 32'd12));
        emit(stype(5'd1, 5'd0, 32'h28c));
        emit(itype(opc_imm, 5'd1, 5'd0, 32'd99));
        emit(stype(5'd5, 5'd0, 32'h290));
        emit(stype(5'd1, 5'd0, 32'h294));
        emit(halt_instr);
        expect_store(32'h288, 32'd7);
        expect_store(32'h290, jal_pc + 32'd4);
        expect_store(32'h294, 32'd7);
        run_program("branch");
        check_stores();
        expect_untouched(32'h280);
        expect_untouched(32'h284);
        expect_untouched(32'h28c);
    endtask

    task automatic zero_reg_and_halt();
        int i;
        new_program();
        emit(itype(opc_imm, 5'd0, 5'd0, 32'd55));
        emit(itype(opc_imm, 5'd1, 5'd0, 32'd3));
        emit(rtype(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
        emit(stype(5'd0, 5'd0, 32'h2c0));
        emit(rtype(7'h00, 3'b000, 5'd2, 5'd0, 5'd1));
        emit(stype(5'd2, 5'd0, 32'h2c4));
        emit(halt_instr);
        // never fetched
        emit(stype(5'd1, 5'd0, 32'h2c8));
        expect_store(32'h2c0, 32'd0);
        expect_store(32'h2c4, 32'd0 + 32'd3);
        run_program("x0 and halt");
        // fetch and memory stay quiet once halted
        for (i = 0; i < 20; i++) begin
            @(negedge CLK);
            compare_flag("halt", halt, 1'b1);
            compare_flag("imemREN", imemREN, 1'b0);
            compare_flag("dmemREN", dmemREN, 1'b0);
            compare_flag("dmemWEN", dmemWEN, 1'b0);
        end
        check_stores();
        expect_untouched(32'h2c8);
    endtask

    initial begin
        void'($urandom(seed));
        alu_ops();
        dependence_chain();
        load_store_roundtrip();
        branch_and_jump();
        zero_reg_and_halt();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/datapath_pkg.sv
hw/datapath_ifs.sv
hw/fetch_stage.sv
hw/scoreboard.sv
hw/regfile.sv
hw/execute.sv
hw/writeback.sv
hw/sc_datapath.sv
testbench/tb_clock.sv
testbench/tb_datapath.sv
